/* source/bridge_pkg.sv */
package bridge_pkg;

  // host side
  typedef logic [14:0]  host_addr_t;
  typedef logic [31:0]  host_word_t;
  typedef logic [255:0] stage_t;     // eight host words

  // axi master fields
  typedef logic [63:0]  axi_addr_t;
  typedef logic [2:0]   axi_size_t;
  typedef logic [127:0] axi_data_t;
  typedef logic [15:0]  axi_strb_t;
  typedef logic [3:0]   axi_id_t;
  typedef logic [1:0]   axi_resp_t;

  // queue entries, packed high to low
  typedef logic [$bits(axi_size_t) + $bits(axi_addr_t) - 1:0] aw_entry_t; // size, addr
  typedef logic [$bits(axi_size_t) + $bits(axi_addr_t) - 1:0] ar_entry_t; // size, addr
  typedef logic [$bits(axi_strb_t) + $bits(axi_data_t) - 1:0] w_entry_t;  // strb, data
  typedef logic [$bits(axi_id_t) + $bits(axi_resp_t) - 1:0]   b_entry_t;  // id, resp
  typedef logic [$bits(axi_id_t) + $bits(axi_resp_t)
                 + $bits(axi_data_t) - 1:0]                   r_entry_t;  // id, resp, data

  // staging words at REG_DATA0 + 4n
  localparam host_addr_t REG_DATA0 = 15'h000;

  // request pushes
  localparam host_addr_t REG_AW_PUSH = 15'h020;
  localparam host_addr_t REG_W_PUSH  = 15'h030;
  localparam host_addr_t REG_AR_PUSH = 15'h040;

  // response status and pops
  localparam host_addr_t REG_B_STATUS = 15'h050;
  localparam host_addr_t REG_B_POP    = 15'h054;
  localparam host_addr_t REG_R_STATUS = 15'h060;
  localparam host_addr_t REG_R_POP    = 15'h064;

  // downstream link reset
  localparam host_addr_t REG_LINK_RST_ON  = 15'h0C0;
  localparam host_addr_t REG_LINK_RST_OFF = 15'h0C4;

  // 512 entries per channel queue
  localparam int FIFO_LOG2_DEPTH = 9;

endpackage

/* source/stream_fifo.sv */
module stream_fifo #(
  parameter int WIDTH      = 32,
  parameter int LOG2_DEPTH = 4
) (
  input  logic             clk,
  input  logic             rstn,
  // write side
  input  logic             wvalid,
  input  logic [WIDTH-1:0] wdata,
  output logic             wready,
  // read side, head shown without a read request
  output logic             rvalid,
  output logic [WIDTH-1:0] rdata,
  input  logic             rready
);

  logic [WIDTH-1:0] mem [2**LOG2_DEPTH];

  logic [LOG2_DEPTH-1:0] wr_ptr;
  logic [LOG2_DEPTH-1:0] rd_ptr;
  logic [LOG2_DEPTH:0]   count;  // one extra bit to tell full from empty

  logic do_push;
  logic do_pop;

  assign wready  = ~count[LOG2_DEPTH]; // msb only set when full
  assign rvalid  = (count != '0);
  assign rdata   = mem[rd_ptr];

  assign do_push = wvalid & wready;
  assign do_pop  = rvalid & rready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // pointers wrap on their own
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* source/host_regs.sv */
module host_regs (
  input  logic                   clk,
  input  logic                   rstn,

  // host memory port
  input  bridge_pkg::host_addr_t host_addr,
  input  bridge_pkg::host_word_t host_din,
  output bridge_pkg::host_word_t host_dout,
  input  logic                   host_en,
  input  logic [3:0]             host_we,

  // request queue pushes
  output logic                   aw_push,
  output bridge_pkg::aw_entry_t  aw_entry,
  output logic                   w_push,
  output bridge_pkg::w_entry_t   w_entry,
  output logic                   ar_push,
  output bridge_pkg::ar_entry_t  ar_entry,

  // response queue heads and pops
  input  logic                   b_avail,
  input  bridge_pkg::b_entry_t   b_entry,
  output logic                   b_pop,
  input  logic                   r_avail,
  input  bridge_pkg::r_entry_t   r_entry,
  output logic                   r_pop,

  // downstream link reset
  output logic                   ocu_rstn
);

  bridge_pkg::stage_t stage;

  logic       host_wr;
  logic       stage_hit;
  logic [2:0] stage_sel;
  logic       link_rst_req;

  assign host_wr = host_en & (host_we != 4'b0000);

  // word aligned hit inside the eight staging words
  assign stage_hit = (host_addr[14:5] == bridge_pkg::REG_DATA0[14:5]) &&
                     (host_addr[1:0] == 2'b00);
  assign stage_sel = host_addr[4:2];

  // entries are the low bits of the staging buffer
  assign aw_entry = stage[$bits(bridge_pkg::aw_entry_t)-1:0];
  assign w_entry  = stage[$bits(bridge_pkg::w_entry_t)-1:0];
  assign ar_entry = stage[$bits(bridge_pkg::ar_entry_t)-1:0];

  // strobes and link reset control
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_push      <= 1'b0;
      w_push       <= 1'b0;
      ar_push      <= 1'b0;
      b_pop        <= 1'b0;
      r_pop        <= 1'b0;
      link_rst_req <= 1'b1;
      ocu_rstn     <= 1'b0;
    end else begin
      aw_push  <= 1'b0;
      w_push   <= 1'b0;
      ar_push  <= 1'b0;
      b_pop    <= 1'b0;
      r_pop    <= 1'b0;
      ocu_rstn <= link_rst_req; // second stage
      if (host_wr) begin
        case (host_addr)
          bridge_pkg::REG_AW_PUSH:      aw_push      <= 1'b1;
          bridge_pkg::REG_W_PUSH:       w_push       <= 1'b1;
          bridge_pkg::REG_AR_PUSH:      ar_push      <= 1'b1;
          bridge_pkg::REG_B_POP:        b_pop        <= 1'b1;
          bridge_pkg::REG_R_POP:        r_pop        <= 1'b1;
          bridge_pkg::REG_LINK_RST_ON:  link_rst_req <= 1'b0;
          bridge_pkg::REG_LINK_RST_OFF: link_rst_req <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // staging buffer and read mux
  always_ff @(posedge clk) begin
    if (host_wr) begin
      if (stage_hit) begin
        stage[stage_sel*32 +: 32] <= host_din;
      end else if (host_addr == bridge_pkg::REG_B_POP) begin
        // head is captured now, popped next cycle
        stage <= bridge_pkg::stage_t'(b_entry);
      end else if (host_addr == bridge_pkg::REG_R_POP) begin
        stage <= bridge_pkg::stage_t'(r_entry);
      end
    end else begin
      if (stage_hit) begin
        host_dout <= stage[stage_sel*32 +: 32];
      end else begin
        case (host_addr)
          bridge_pkg::REG_B_STATUS: host_dout <= bridge_pkg::host_word_t'(b_avail);
          bridge_pkg::REG_R_STATUS: host_dout <= bridge_pkg::host_word_t'(r_avail);
          default:                  host_dout <= '0; // unmapped
        endcase
      end
    end
  end

endmodule

/* source/axi_req_resp.sv */
module axi_req_resp (
  input  logic                  clk,
  input  logic                  rstn,

  // pushes from the register window
  input  logic                  aw_push,
  input  bridge_pkg::aw_entry_t aw_entry,
  input  logic                  w_push,
  input  bridge_pkg::w_entry_t  w_entry,
  input  logic                  ar_push,
  input  bridge_pkg::ar_entry_t ar_entry,

  // response heads back to the register window
  input  logic                  b_pop,
  output logic                  b_avail,
  output bridge_pkg::b_entry_t  b_entry,
  input  logic                  r_pop,
  output logic                  r_avail,
  output bridge_pkg::r_entry_t  r_entry,

  // aw
  output logic                  awvalid,
  input  logic                  awready,
  output bridge_pkg::axi_addr_t awaddr,
  output bridge_pkg::axi_size_t awsize,
  // w
  output logic                  wvalid,
  input  logic                  wready,
  output bridge_pkg::axi_data_t wdata,
  output bridge_pkg::axi_strb_t wstrb,
  // ar
  output logic                  arvalid,
  input  logic                  arready,
  output bridge_pkg::axi_addr_t araddr,
  output bridge_pkg::axi_size_t arsize,
  // b
  input  logic                  bvalid,
  output logic                  bready,
  input  bridge_pkg::axi_id_t   bid,
  input  bridge_pkg::axi_resp_t bresp,
  // r
  input  logic                  rvalid,
  output logic                  rready,
  input  bridge_pkg::axi_id_t   rid,
  input  bridge_pkg::axi_resp_t rresp,
  input  bridge_pkg::axi_data_t rdata
);

  bridge_pkg::aw_entry_t aw_head;
  bridge_pkg::w_entry_t  w_head;
  bridge_pkg::ar_entry_t ar_head;

  assign {awsize, awaddr} = aw_head;
  assign {wstrb, wdata}   = w_head;
  assign {arsize, araddr} = ar_head;

  // request queues, a push into a full queue is dropped
  stream_fifo #(
    .WIDTH      ($bits(bridge_pkg::aw_entry_t)),
    .LOG2_DEPTH (bridge_pkg::FIFO_LOG2_DEPTH)
  ) aw_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (aw_push),
    .wdata  (aw_entry),
    .wready (),
    .rvalid (awvalid),
    .rdata  (aw_head),
    .rready (awready)
  );

  stream_fifo #(
    .WIDTH      ($bits(bridge_pkg::w_entry_t)),
    .LOG2_DEPTH (bridge_pkg::FIFO_LOG2_DEPTH)
  ) w_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (w_push),
    .wdata  (w_entry),
    .wready (),
    .rvalid (wvalid),
    .rdata  (w_head),
    .rready (wready)
  );

  stream_fifo #(
    .WIDTH      ($bits(bridge_pkg::ar_entry_t)),
    .LOG2_DEPTH (bridge_pkg::FIFO_LOG2_DEPTH)
  ) ar_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (ar_push),
    .wdata  (ar_entry),
    .wready (),
    .rvalid (arvalid),
    .rdata  (ar_head),
    .rready (arready)
  );

  // response queues, ready toward the slave whenever there is room
  stream_fifo #(
    .WIDTH      ($bits(bridge_pkg::b_entry_t)),
    .LOG2_DEPTH (bridge_pkg::FIFO_LOG2_DEPTH)
  ) b_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (bvalid),
    .wdata  ({bid, bresp}),
    .wready (bready),
    .rvalid (b_avail),
    .rdata  (b_entry),
    .rready (b_pop)
  );

  stream_fifo #(
    .WIDTH      ($bits(bridge_pkg::r_entry_t)),
    .LOG2_DEPTH (bridge_pkg::FIFO_LOG2_DEPTH)
  ) r_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (rvalid),
    .wdata  ({rid, rresp, rdata}),
    .wready (rready),
    .rvalid (r_avail),
    .rdata  (r_entry),
    .rready (r_pop)
  );

endmodule

/* source/kernel_bridge.sv */
module kernel_bridge (
  input  logic                   clk,
  input  logic                   rstn,
  output logic                   ocu_rstn,

  // host memory port
  input  bridge_pkg::host_addr_t host_addr,
  input  bridge_pkg::host_word_t host_din,
  output bridge_pkg::host_word_t host_dout,
  input  logic                   host_en,
  input  logic [3:0]             host_we,

  // axi master
  output logic                   awvalid,
  input  logic                   awready,
  output bridge_pkg::axi_addr_t  awaddr,
  output bridge_pkg::axi_size_t  awsize,
  output logic                   wvalid,
  input  logic                   wready,
  output bridge_pkg::axi_data_t  wdata,
  output bridge_pkg::axi_strb_t  wstrb,
  output logic                   arvalid,
  input  logic                   arready,
  output bridge_pkg::axi_addr_t  araddr,
  output bridge_pkg::axi_size_t  arsize,
  input  logic                   bvalid,
  output logic                   bready,
  input  bridge_pkg::axi_id_t    bid,
  input  bridge_pkg::axi_resp_t  bresp,
  input  logic                   rvalid,
  output logic                   rready,
  input  bridge_pkg::axi_id_t    rid,
  input  bridge_pkg::axi_resp_t  rresp,
  input  bridge_pkg::axi_data_t  rdata
);

  logic                  aw_push;
  logic                  w_push;
  logic                  ar_push;
  logic                  b_pop;
  logic                  r_pop;
  logic                  b_avail;
  logic                  r_avail;
  bridge_pkg::aw_entry_t aw_entry;
  bridge_pkg::w_entry_t  w_entry;
  bridge_pkg::ar_entry_t ar_entry;
  bridge_pkg::b_entry_t  b_entry;
  bridge_pkg::r_entry_t  r_entry;

  host_regs regs0 (
    .clk       (clk),       .rstn      (rstn),
    .host_addr (host_addr), .host_din  (host_din),  .host_dout (host_dout),
    .host_en   (host_en),   .host_we   (host_we),
    .aw_push   (aw_push),   .aw_entry  (aw_entry),
    .w_push    (w_push),    .w_entry   (w_entry),
    .ar_push   (ar_push),   .ar_entry  (ar_entry),
    .b_avail   (b_avail),   .b_entry   (b_entry),   .b_pop     (b_pop),
    .r_avail   (r_avail),   .r_entry   (r_entry),   .r_pop     (r_pop),
    .ocu_rstn  (ocu_rstn)
  );

  axi_req_resp axi0 (
    .clk      (clk),      .rstn     (rstn),
    .aw_push  (aw_push),  .aw_entry (aw_entry),
    .w_push   (w_push),   .w_entry  (w_entry),
    .ar_push  (ar_push),  .ar_entry (ar_entry),
    .b_pop    (b_pop),    .b_avail  (b_avail),  .b_entry (b_entry),
    .r_pop    (r_pop),    .r_avail  (r_avail),  .r_entry (r_entry),
    .awvalid  (awvalid),  .awready  (awready),  .awaddr  (awaddr),  .awsize (awsize),
    .wvalid   (wvalid),   .wready   (wready),   .wdata   (wdata),   .wstrb  (wstrb),
    .arvalid  (arvalid),  .arready  (arready),  .araddr  (araddr),  .arsize (arsize),
    .bvalid   (bvalid),   .bready   (bready),   .bid     (bid),     .bresp  (bresp),
    .rvalid   (rvalid),   .rready   (rready),   .rid     (rid),     .rresp  (rresp),
    .rdata    (rdata)
  );

endmodule

/* verif/tb_kernel_bridge.sv */
module tb_kernel_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 100;
  localparam int N_REQ           = 6;    // pushes per request channel
  localparam int WATCHDOG_CYCLES = 2000; // roughly ten times the full run

  logic                   clk;
  logic                   rstn;
  logic                   ocu_rstn;
  bridge_pkg::host_addr_t host_addr;
  bridge_pkg::host_word_t host_din;
  bridge_pkg::host_word_t host_dout;
  logic                   host_en;
  logic [3:0]             host_we;
  logic                   awvalid;
  logic                   awready;
  bridge_pkg::axi_addr_t  awaddr;
  bridge_pkg::axi_size_t  awsize;
  logic                   wvalid;
  logic                   wready;
  bridge_pkg::axi_data_t  wdata;
  bridge_pkg::axi_strb_t  wstrb;
  logic                   arvalid;
  logic                   arready;
  bridge_pkg::axi_addr_t  araddr;
  bridge_pkg::axi_size_t  arsize;
  logic                   bvalid;
  logic                   bready;
  bridge_pkg::axi_id_t    bid;
  bridge_pkg::axi_resp_t  bresp;
  logic                   rvalid;
  logic                   rready;
  bridge_pkg::axi_id_t    rid;
  bridge_pkg::axi_resp_t  rresp;
  bridge_pkg::axi_data_t  rdata;

  // expected request entries filled before each push
  bridge_pkg::aw_entry_t exp_aw [N_REQ];
  bridge_pkg::ar_entry_t exp_ar [N_REQ];
  bridge_pkg::w_entry_t  exp_w  [N_REQ];
  int aw_wr = 0;
  int aw_rd = 0;
  int ar_wr = 0;
  int ar_rd = 0;
  int w_wr  = 0;
  int w_rd  = 0;

  int errors       = 0;
  int err_mark     = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  logic host_wr_cyc;
  assign host_wr_cyc = host_en && (host_we != 4'b0000);

  kernel_bridge dut0 (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // slave stub with random ready stalls on the request channels
  always @(posedge clk) begin
    #10;
    awready = ($urandom % 3) != 0;
    wready  = ($urandom % 3) != 0;
    arready = ($urandom % 3) != 0;
  end

  // count accepted beats
  always @(posedge clk) begin
    if (awvalid && awready) aw_rd <= aw_rd + 1;
    if (wvalid && wready)   w_rd  <= w_rd + 1;
    if (arvalid && arready) ar_rd <= ar_rd + 1;
  end

  task automatic log_error(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  after_reset: assert property (@(posedge clk) $rose(rstn) |->
    !awvalid && !wvalid && !arvalid && bready && rready ##[1:2] ocu_rstn)
    else log_error("outputs wrong after reset release");

  aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    awvalid && !awready |=> awvalid && $stable({awsize, awaddr}))
    else log_error("aw valid or fields changed under stall");
  w_hold: assert property (@(posedge clk) disable iff (!rstn)
    wvalid && !wready |=> wvalid && $stable({wstrb, wdata}))
    else log_error("w valid or fields changed under stall");
  ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && !arready |=> arvalid && $stable({arsize, araddr}))
    else log_error("ar valid or fields changed under stall");

  aw_value: assert property (@(posedge clk) disable iff (!rstn)
    awvalid && awready |-> aw_rd < aw_wr && {awsize, awaddr} == exp_aw[aw_rd])
    else log_error("aw beat differs from the staged entry");
  w_value: assert property (@(posedge clk) disable iff (!rstn)
    wvalid && wready |-> w_rd < w_wr && {wstrb, wdata} == exp_w[w_rd])
    else log_error("w beat differs from the staged entry");
  ar_value: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && arready |-> ar_rd < ar_wr && {arsize, araddr} == exp_ar[ar_rd])
    else log_error("ar beat differs from the staged entry");

  // valid two edges after the push write
  aw_rise: assert property (@(posedge clk) disable iff (!rstn)
    host_wr_cyc && host_addr == bridge_pkg::REG_AW_PUSH |-> ##2 awvalid)
    else log_error("awvalid not high two edges after push");
  w_rise: assert property (@(posedge clk) disable iff (!rstn)
    host_wr_cyc && host_addr == bridge_pkg::REG_W_PUSH |-> ##2 wvalid)
    else log_error("wvalid not high two edges after push");
  ar_rise: assert property (@(posedge clk) disable iff (!rstn)
    host_wr_cyc && host_addr == bridge_pkg::REG_AR_PUSH |-> ##2 arvalid)
    else log_error("arvalid not high two edges after push");

  link_down: assert property (@(posedge clk) disable iff (!rstn)
    host_wr_cyc && host_addr == bridge_pkg::REG_LINK_RST_ON |-> ##2 !ocu_rstn)
    else log_error("ocu_rstn not low two edges after link reset on");
  link_up: assert property (@(posedge clk) disable iff (!rstn)
    host_wr_cyc && host_addr == bridge_pkg::REG_LINK_RST_OFF |-> ##2 ocu_rstn)
    else log_error("ocu_rstn not high two edges after link reset off");

  function automatic bridge_pkg::host_addr_t stage_addr(input int n);
    return bridge_pkg::REG_DATA0 + bridge_pkg::host_addr_t'(4 * n);
  endfunction

  // called 10 ns after an edge and returns at the same phase
  task automatic host_write(input bridge_pkg::host_addr_t addr,
                            input bridge_pkg::host_word_t data);
    host_addr = addr;
    host_din  = data;
    host_en   = 1'b1;
    host_we   = 4'hF;
    @(posedge clk);
    #10;
    host_en = 1'b0;
    host_we = 4'h0;
    @(posedge clk); // idle cycle between writes
    #10;
  endtask

  task automatic host_read(input bridge_pkg::host_addr_t addr,
                           output bridge_pkg::host_word_t data);
    host_addr = addr;
    host_en   = 1'b1;
    host_we   = 4'h0;
    @(posedge clk);
    #10;
    data    = host_dout;
    host_en = 1'b0;
  endtask

  task automatic check_read(input bridge_pkg::host_addr_t addr,
                            input bridge_pkg::host_word_t want);
    bridge_pkg::host_word_t got;
    host_read(addr, got);
    assert (got == want) else
      log_error($sformatf("read 0x%03h got %08h, expected %08h", addr, got, want));
  endtask

  // one scripted beat on b or r held until accepted
  task automatic send_response(input logic to_r, input bridge_pkg::axi_id_t id,
                               input bridge_pkg::axi_resp_t resp,
                               input bridge_pkg::axi_data_t data);
    logic taken;
    int   waited;
    taken  = 1'b0;
    waited = 0;
    if (to_r) begin
      rvalid = 1'b1;
      rid    = id;
      rresp  = resp;
      rdata  = data;
    end else begin
      bvalid = 1'b1;
      bid    = id;
      bresp  = resp;
    end
    while (!taken && waited < 50) begin
      taken = to_r ? rready : bready; // stable up to the edge
      @(posedge clk);
      #10;
      waited++;
    end
    bvalid = 1'b0;
    rvalid = 1'b0;
    if (!taken) note_failure("timeout: response beat was never accepted by the bridge");
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((aw_rd != aw_wr || ar_rd != ar_wr || w_rd != w_wr) && cycles < 300) begin
      @(posedge clk);
      #10;
      cycles++;
    end
    if (aw_rd != aw_wr || ar_rd != ar_wr || w_rd != w_wr) begin
      note_failure("timeout: request queues did not drain onto the AXI port");
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    bridge_pkg::host_word_t words [8];
    bridge_pkg::axi_id_t    ids   [2];
    bridge_pkg::axi_resp_t  resps [2];
    bridge_pkg::axi_data_t  beats [2];

    void'($urandom(32'h74e5_a38a));
    rstn      = 1'b0;
    host_addr = '0;
    host_din  = '0;
    host_en   = 1'b0;
    host_we   = 4'h0;
    awready   = 1'b0;
    wready    = 1'b0;
    arready   = 1'b0;
    bvalid    = 1'b0;
    bid       = '0;
    bresp     = '0;
    rvalid    = 1'b0;
    rid       = '0;
    rresp     = '0;
    rdata     = '0;
    repeat (3) @(posedge clk);
    #10;
    rstn = 1'b1;

    @(posedge clk);
    #10;
    assert (!awvalid && !wvalid && !arvalid && ocu_rstn) else
      log_error("valids not low or ocu_rstn not high after reset");
    report_test("reset");

    for (int i = 0; i < 8; i++) begin
      words[i] = $urandom;
      host_write(stage_addr(i), words[i]);
    end
    for (int i = 0; i < 8; i++) check_read(stage_addr(i), words[i]);
    report_test("staging");

    // address from words 1:0 and size from word 2
    for (int n = 0; n < N_REQ; n++) begin
      for (int i = 0; i < 3; i++) begin
        words[i] = $urandom;
        host_write(stage_addr(i), words[i]);
      end
      exp_aw[aw_wr] = {words[2][2:0], words[1], words[0]};
      aw_wr++;
      host_write(bridge_pkg::REG_AW_PUSH, '0);
      words[0] = $urandom;
      host_write(stage_addr(0), words[0]);
      exp_ar[ar_wr] = {words[2][2:0], words[1], words[0]};
      ar_wr++;
      host_write(bridge_pkg::REG_AR_PUSH, '0);
    end
    wait_drain();
    report_test("aw_ar");

    for (int n = 0; n < N_REQ; n++) begin
      for (int i = 0; i < 5; i++) begin
        words[i] = $urandom;
        host_write(stage_addr(i), words[i]);
      end
      exp_w[w_wr] = {words[4][15:0], words[3], words[2], words[1], words[0]};
      w_wr++;
      host_write(bridge_pkg::REG_W_PUSH, '0);
    end
    wait_drain();
    report_test("w");

    for (int n = 0; n < 2; n++) begin
      ids[n]   = bridge_pkg::axi_id_t'($urandom);
      resps[n] = bridge_pkg::axi_resp_t'($urandom);
      send_response(1'b0, ids[n], resps[n], '0);
    end
    check_read(bridge_pkg::REG_B_STATUS, 32'd1);
    for (int n = 0; n < 2; n++) begin
      // stale ones the pop has to clear
      host_write(stage_addr(0), 32'hFFFF_FFFF);
      host_write(stage_addr(1), 32'hFFFF_FFFF);
      host_write(bridge_pkg::REG_B_POP, '0);
      check_read(stage_addr(0), {26'b0, ids[n], resps[n]});
      check_read(stage_addr(1), '0);
      check_read(bridge_pkg::REG_B_STATUS, (n == 0) ? 32'd1 : 32'd0);
    end
    for (int n = 0; n < 2; n++) begin
      ids[n]   = bridge_pkg::axi_id_t'($urandom);
      resps[n] = bridge_pkg::axi_resp_t'($urandom);
      beats[n] = {$urandom, $urandom, $urandom, $urandom};
      send_response(1'b1, ids[n], resps[n], beats[n]);
    end
    check_read(bridge_pkg::REG_R_STATUS, 32'd1);
    for (int n = 0; n < 2; n++) begin
      // stale ones above the entry
      host_write(stage_addr(4), 32'hFFFF_FFFF);
      host_write(stage_addr(5), 32'hFFFF_FFFF);
      host_write(bridge_pkg::REG_R_POP, '0);
      for (int i = 0; i < 4; i++) check_read(stage_addr(i), beats[n][32*i +: 32]);
      check_read(stage_addr(4), {26'b0, ids[n], resps[n]});
      check_read(stage_addr(5), '0);
      check_read(bridge_pkg::REG_R_STATUS, (n == 0) ? 32'd1 : 32'd0);
    end
    report_test("b_r");

    host_write(bridge_pkg::REG_LINK_RST_ON, '0);
    assert (!ocu_rstn) else log_error("ocu_rstn still high after link reset on");
    host_write(bridge_pkg::REG_LINK_RST_OFF, '0);
    assert (ocu_rstn) else log_error("ocu_rstn still low after link reset off");
    report_test("link_reset");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d clock periods, the run did not finish",
             WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* kernel_bridge.f */
source/bridge_pkg.sv
source/stream_fifo.sv
source/host_regs.sv
source/axi_req_resp.sv
source/kernel_bridge.sv
verif/tb_kernel_bridge.sv

/* Bender.yml */
package:
  name: kernel_bridge

sources:
  # rtl, package first
  - source/bridge_pkg.sv
  - source/stream_fifo.sv
  - source/host_regs.sv
  - source/axi_req_resp.sv
  - source/kernel_bridge.sv

  # testbench
  - target: test
    files:
      - verif/tb_kernel_bridge.sv
